// File: hw/cache_pkg.sv
package cache_pkg;

	// geometry
	// --------------------
	localparam int WORD_BITS      = 32;   // data word
	localparam int ADDR_BITS      = 16;   // word address
	localparam int WORDS_PER_LINE = 4;    // words in one block
	localparam int OFFSET_BITS    = 2;    // word-in-block index
	localparam int NUM_SETS       = 4;
	localparam int SET_BITS       = 2;
	localparam int NUM_WAYS       = 2;    // two-way set associative
	localparam int TAG_BITS       = ADDR_BITS - SET_BITS - OFFSET_BITS;

	// vector types
	// --------------------
	typedef logic [WORD_BITS-1:0]   word_t;
	typedef logic [ADDR_BITS-1:0]   addr_t;   // {tag, set, offset}
	typedef logic [TAG_BITS-1:0]    tag_t;
	typedef logic [SET_BITS-1:0]    set_t;
	typedef logic [OFFSET_BITS-1:0] offset_t;
	typedef logic                   way_t;    // one bit covers two ways

	// one extra bit so the counter can reach WORDS_PER_LINE
	typedef logic [OFFSET_BITS:0]   count_t;

	// sequencer FSM
	// --------------------
	typedef enum logic [2:0] {
		ST_LOOKUP    = 3'd0,  // hit/miss check on the core request
		ST_REQUEST   = 3'd1,  // wait for next level, pick write-back or fill
		ST_WRITEBACK = 3'd2,  // stream dirty victim out
		ST_FILL      = 3'd3,  // stream new block in
		ST_REPLAY    = 3'd4   // serve the stalled request as a hit
	} seq_state_t;

endpackage

// File: hw/lookup_if.sv
`timescale 1ns/1ps

// sequencer <-> tag store
interface lookup_if;

	cache_pkg::tag_t tag;         // tag of the current address
	cache_pkg::set_t set;         // set of the current address
	logic            tag_wr_en;   // write tag, set valid
	cache_pkg::way_t tag_wr_way;  // way to write, also selects victim_tag
	logic            hit;
	cache_pkg::way_t hit_way;
	cache_pkg::tag_t victim_tag;  // old tag in tag_wr_way

	modport sequencer (
		output tag, set, tag_wr_en, tag_wr_way,
		input  hit, hit_way, victim_tag
	);

	modport store (
		input  tag, set, tag_wr_en, tag_wr_way,
		output hit, hit_way, victim_tag
	);

endinterface

// File: hw/victim_if.sv
`timescale 1ns/1ps

// sequencer <-> victim selector
interface victim_if;

	cache_pkg::set_t set;
	logic            miss_pulse;    // one cycle per miss
	logic            mark_dirty;    // store hit on (set, mark_way)
	logic            clear_dirty;   // victim line written back
	cache_pkg::way_t mark_way;
	cache_pkg::way_t victim_way;    // valid one cycle after miss_pulse
	logic            victim_dirty;

	modport sequencer (
		output set, miss_pulse, mark_dirty, clear_dirty, mark_way,
		input  victim_way, victim_dirty
	);

	modport selector (
		input  set, miss_pulse, mark_dirty, clear_dirty, mark_way,
		output victim_way, victim_dirty
	);

endinterface

// File: hw/tag_store.sv
`timescale 1ns/1ps

module tag_store (
	input logic     clock_i,
	input logic     resetn_i,
	lookup_if.store lk
);

	// storage
	// --------------------
	cache_pkg::tag_t tag_q [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
	logic [cache_pkg::NUM_WAYS-1:0] valid_q [cache_pkg::NUM_SETS];

	logic [cache_pkg::NUM_WAYS-1:0] match;  // per-way compare result
	cache_pkg::way_t hit_way;

	// lookup, purely combinational
	// --------------------
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
			match[w] = valid_q[lk.set][w] && (tag_q[lk.set][w] == lk.tag);
			if (match[w]) begin
				hit_way = cache_pkg::way_t'(w);  // last match wins, only one expected
			end
		end
	end

	assign lk.hit        = |match;
	assign lk.hit_way    = hit_way;
	assign lk.victim_tag = tag_q[lk.set][lk.tag_wr_way];  // old tag for write-back address

	// tag write
	// --------------------
	always_ff @(posedge clock_i) begin
		if (lk.tag_wr_en) begin
			tag_q[lk.set][lk.tag_wr_way] <= lk.tag;
		end
	end

	// valid bits
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '{default: '0};  // empty cache
		end else if (lk.tag_wr_en) begin
			valid_q[lk.set][lk.tag_wr_way] <= 1'b1;
		end
	end

	// a block lives in at most one way of its set
	// relies on the sequencer only filling after a real miss
	a_single_way_hit: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		$onehot0(match)
	) else $error("tag_store: tag present in more than one way");

endmodule

// File: hw/victim_select.sv
`timescale 1ns/1ps

module victim_select (
	input logic        clock_i,
	input logic        resetn_i,
	victim_if.selector vc
);

	// fifo pointer per set, names the way replaced next
	cache_pkg::way_t fifo_ptr_q [cache_pkg::NUM_SETS];

	// dirty bit per line
	logic [cache_pkg::NUM_WAYS-1:0] dirty_q [cache_pkg::NUM_SETS];

	cache_pkg::way_t victim_way_q;  // latched on miss_pulse

	// replacement and dirty tracking
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			fifo_ptr_q   <= '{default: '0};
			dirty_q      <= '{default: '0};
			victim_way_q <= '0;
		end else begin
			if (vc.miss_pulse) begin
				victim_way_q <= fifo_ptr_q[vc.set];                 // oldest way in the set
				fifo_ptr_q[vc.set] <= fifo_ptr_q[vc.set] + 1'b1;    // next one in line
			end
			if (vc.mark_dirty) begin
				dirty_q[vc.set][vc.mark_way] <= 1'b1;  // store hit
			end
			if (vc.clear_dirty) begin
				dirty_q[vc.set][victim_way_q] <= 1'b0;  // line now clean in next level
			end
		end
	end

	assign vc.victim_way   = victim_way_q;
	assign vc.victim_dirty = dirty_q[vc.set][victim_way_q];

	// a store never lands on the line that is being written back
	a_dirty_exclusive: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		!(vc.mark_dirty && vc.clear_dirty && (vc.mark_way == victim_way_q))
	) else $error("victim_select: mark and clear on the same line");

endmodule

// File: hw/cache_sequencer.sv
`timescale 1ns/1ps

module cache_sequencer (
	input  logic              clock_i,
	input  logic              resetn_i,
	input  logic              enable_i,
	// core port
	input  logic              core_req_i,
	input  logic              core_rw_i,        // 1 store, 0 load
	input  cache_pkg::addr_t  core_addr_i,
	input  cache_pkg::word_t  core_data_i,
	output cache_pkg::word_t  core_data_o,
	output logic              core_done_o,
	output logic              core_hit_o,
	// fill stream in
	input  logic              fill_valid_i,
	input  cache_pkg::word_t  fill_data_i,
	output logic              fill_ack_o,
	// write-back stream out
	input  logic              wb_ready_i,
	output logic              wb_valid_o,
	output cache_pkg::word_t  wb_data_o,
	// next-level command
	input  logic              mem_ready_i,
	output logic              mem_req_o,
	output logic              mem_rw_o,         // 1 write-back, 0 fill
	output cache_pkg::addr_t  mem_addr_o,
	// performance pulses
	output logic              flag_hit_o,
	output logic              flag_miss_o,
	output logic              flag_writeback_o,
	lookup_if.sequencer       lk,
	victim_if.sequencer       vc
);

	cache_pkg::seq_state_t state_q;
	cache_pkg::count_t     cnt_q;     // words moved in this block
	cache_pkg::count_t     cnt_next;
	logic                  xfer_last;

	// latched missing request
	cache_pkg::addr_t req_addr_q;
	logic             req_rw_q;
	cache_pkg::word_t req_data_q;

	// data array, set x way x offset
	cache_pkg::word_t data_q [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS][cache_pkg::WORDS_PER_LINE];

	cache_pkg::addr_t   cur_addr;
	cache_pkg::tag_t    cur_tag;
	cache_pkg::set_t    cur_set;
	cache_pkg::offset_t cur_off;
	logic               cur_rw;
	cache_pkg::word_t   cur_wdata;

	logic serve, miss_start, cmd_issue, wb_fire, fill_fire;
	logic data_we;
	cache_pkg::way_t    data_way;
	cache_pkg::offset_t data_off;
	cache_pkg::word_t   data_wdata;

	// request decode
	// --------------------
	assign cur_addr  = (state_q == cache_pkg::ST_LOOKUP) ? core_addr_i : req_addr_q;
	assign cur_rw    = (state_q == cache_pkg::ST_LOOKUP) ? core_rw_i : req_rw_q;
	assign cur_wdata = (state_q == cache_pkg::ST_LOOKUP) ? core_data_i : req_data_q;
	assign cur_tag   = cur_addr[cache_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];
	assign cur_set   = cur_addr[cache_pkg::OFFSET_BITS +: cache_pkg::SET_BITS];
	assign cur_off   = cur_addr[cache_pkg::OFFSET_BITS-1:0];

	// access strobes, all held off while disabled
	assign serve      = enable_i && ((state_q == cache_pkg::ST_LOOKUP && core_req_i && lk.hit)
	                    || state_q == cache_pkg::ST_REPLAY);
	assign miss_start = enable_i && state_q == cache_pkg::ST_LOOKUP && core_req_i && !lk.hit;
	assign cmd_issue  = enable_i && state_q == cache_pkg::ST_REQUEST && mem_ready_i;
	assign wb_valid_o = enable_i && state_q == cache_pkg::ST_WRITEBACK;
	assign fill_ack_o = enable_i && state_q == cache_pkg::ST_FILL && fill_valid_i;
	assign wb_fire    = wb_valid_o && wb_ready_i;
	assign fill_fire  = fill_ack_o;

	assign cnt_next  = cnt_q + 1'b1;
	assign xfer_last = (cnt_next == cache_pkg::count_t'(cache_pkg::WORDS_PER_LINE));

	// no request means nothing to stall on
	assign core_hit_o = (core_req_i || state_q != cache_pkg::ST_LOOKUP) ? lk.hit : 1'b1;

	// tag store and victim selector
	// --------------------
	assign lk.tag        = cur_tag;
	assign lk.set        = cur_set;
	assign lk.tag_wr_way = vc.victim_way;     // also gives the old tag
	assign lk.tag_wr_en  = fill_fire && xfer_last;

	assign vc.set         = cur_set;
	assign vc.miss_pulse  = miss_start;
	assign vc.mark_dirty  = serve && cur_rw;
	assign vc.mark_way    = lk.hit_way;
	assign vc.clear_dirty = wb_fire && xfer_last;

	// data array port
	assign data_we    = (serve && cur_rw) || fill_fire;
	assign data_way   = fill_fire ? vc.victim_way : lk.hit_way;
	assign data_off   = fill_fire ? cnt_q[cache_pkg::OFFSET_BITS-1:0] : cur_off;
	assign data_wdata = fill_fire ? fill_data_i : cur_wdata;

	assign wb_data_o = data_q[cur_set][vc.victim_way][cnt_q[cache_pkg::OFFSET_BITS-1:0]];

	// control FSM
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q          <= cache_pkg::ST_LOOKUP;
			cnt_q            <= '0;
			core_done_o      <= 1'b1;
			mem_req_o        <= 1'b0;
			flag_hit_o       <= 1'b0;
			flag_miss_o      <= 1'b0;
			flag_writeback_o <= 1'b0;
		end else begin
			mem_req_o        <= 1'b0;  // pulses by default
			flag_hit_o       <= 1'b0;
			flag_miss_o      <= 1'b0;
			flag_writeback_o <= 1'b0;
			if (enable_i) begin
				case (state_q)
					cache_pkg::ST_LOOKUP: begin
						flag_hit_o <= serve;  // first-time hits only
						if (miss_start) begin
							core_done_o <= 1'b0;  // stall core
							flag_miss_o <= 1'b1;
							state_q     <= cache_pkg::ST_REQUEST;
						end
					end
					cache_pkg::ST_REQUEST: begin
						if (cmd_issue) begin
							mem_req_o <= 1'b1;
							if (vc.victim_dirty) begin
								flag_writeback_o <= 1'b1;
								state_q <= cache_pkg::ST_WRITEBACK;
							end else begin
								state_q <= cache_pkg::ST_FILL;
							end
						end
					end
					cache_pkg::ST_WRITEBACK: begin
						if (wb_fire) begin
							cnt_q <= xfer_last ? '0 : cnt_next;
							if (xfer_last) begin
								state_q <= cache_pkg::ST_REQUEST;  // now clean, fill comes next
							end
						end
					end
					cache_pkg::ST_FILL: begin
						if (fill_fire) begin
							cnt_q <= xfer_last ? '0 : cnt_next;
							if (xfer_last) begin
								state_q <= cache_pkg::ST_REPLAY;
							end
						end
					end
					cache_pkg::ST_REPLAY: begin
						core_done_o <= 1'b1;  // data lands in the same edge
						state_q     <= cache_pkg::ST_LOOKUP;
					end
					default: state_q <= cache_pkg::ST_LOOKUP;
				endcase
			end
		end
	end

	// payload, data array and command fields
	// --------------------
	always_ff @(posedge clock_i) begin
		if (data_we) begin
			data_q[cur_set][data_way][data_off] <= data_wdata;
		end
		if (miss_start) begin
			req_addr_q <= core_addr_i;
			req_rw_q   <= core_rw_i;
			req_data_q <= core_data_i;
		end
		if (serve && !cur_rw) begin
			core_data_o <= data_q[cur_set][lk.hit_way][cur_off];
		end
		if (cmd_issue) begin
			mem_rw_o   <= vc.victim_dirty;
			mem_addr_o <= vc.victim_dirty
				? {lk.victim_tag, cur_set, {cache_pkg::OFFSET_BITS{1'b0}}}  // old line base
				: {cur_tag, cur_set, {cache_pkg::OFFSET_BITS{1'b0}}};       // new block base
		end
	end

	// fill only while the missing tag is still absent
	a_fill_ack: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		fill_ack_o |-> fill_valid_i && !lk.hit
	) else $error("cache_sequencer: bad fill ack");

	// command pulse follows a cycle with mem_ready_i high
	a_mem_req: assert property (
		@(posedge clock_i) disable iff (!resetn_i)
		mem_req_o |-> $past(mem_ready_i)
	) else $error("cache_sequencer: command without ready");

endmodule

// File: hw/l1_cache_top.sv
`timescale 1ns/1ps

module l1_cache_top (
	input  logic             clock_i,
	input  logic             resetn_i,
	input  logic             enable_i,
	// core
	input  logic             core_req_i,
	input  logic             core_rw_i,
	input  cache_pkg::addr_t core_addr_i,
	input  cache_pkg::word_t core_data_i,
	output cache_pkg::word_t core_data_o,
	output logic             core_done_o,
	output logic             core_hit_o,
	// fill stream
	input  logic             fill_valid_i,
	input  cache_pkg::word_t fill_data_i,
	output logic             fill_ack_o,
	// write-back stream
	input  logic             wb_ready_i,
	output logic             wb_valid_o,
	output cache_pkg::word_t wb_data_o,
	// memory command
	input  logic             mem_ready_i,
	output logic             mem_req_o,
	output logic             mem_rw_o,
	output cache_pkg::addr_t mem_addr_o,
	// performance
	output logic             flag_hit_o,
	output logic             flag_miss_o,
	output logic             flag_writeback_o
);

	lookup_if lk_bus ();  // sequencer <-> tag store
	victim_if vc_bus ();  // sequencer <-> fifo/dirty

	tag_store u_tag_store (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.lk       (lk_bus)
	);

	victim_select u_victim_select (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.vc       (vc_bus)
	);

	cache_sequencer u_sequencer (
		.clock_i, .resetn_i, .enable_i,
		.core_req_i, .core_rw_i, .core_addr_i, .core_data_i,
		.core_data_o, .core_done_o, .core_hit_o,
		.fill_valid_i, .fill_data_i, .fill_ack_o,
		.wb_ready_i, .wb_valid_o, .wb_data_o,
		.mem_ready_i, .mem_req_o, .mem_rw_o, .mem_addr_o,
		.flag_hit_o, .flag_miss_o, .flag_writeback_o,
		.lk (lk_bus),
		.vc (vc_bus)
	);

endmodule

// File: sim/tb_l1_cache.sv
`timescale 1ns/1ps

module tb_l1_cache;

	localparam int TAB_LEN   = 64;  // fixed entries, then random ones
	localparam int MISS_MAX  = 40;  // worst-case cycles per access

	bit               clock_i;
	logic             resetn_i, enable_i;
	logic             core_req_i, core_rw_i, core_done_o, core_hit_o;
	cache_pkg::addr_t core_addr_i, mem_addr_o;
	cache_pkg::word_t core_data_i, core_data_o, fill_data_i, wb_data_o;
	logic             fill_valid_i, fill_ack_o, wb_ready_i, wb_valid_o;
	logic             mem_ready_i, mem_req_o, mem_rw_o;
	logic             flag_hit_o, flag_miss_o, flag_writeback_o;

	// stimulus table, rw / address / store data
	logic             tab_rw   [TAB_LEN];
	cache_pkg::addr_t tab_addr [TAB_LEN];
	cache_pkg::word_t tab_data [TAB_LEN];

	cache_pkg::word_t mem_model [65536];  // next level
	cache_pkg::word_t arch_mem  [65536];  // what a load must return

	// reference cache
	cache_pkg::tag_t ref_tag   [4][2];
	logic            ref_valid [4][2];
	logic            ref_dirty [4][2];
	logic            ref_ptr   [4];     // fifo pointer per set

	logic [16:0]      cmd_q [$];        // {rw, block address}
	logic             fill_active, wb_active;
	int               fill_idx, wb_idx, fill_words, wb_words, wb_flags;
	cache_pkg::addr_t fill_base, wb_base, init_addr;
	logic [31:0]      rng_q;
	int               err_cnt, check_cnt;

	l1_cache_top UUT (.*);

	initial begin
		clock_i = 1'b0;
		forever #50 clock_i = ~clock_i;
	end

	// helpers
	// --------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_q = xorshift(rng_q);
		return rng_q;
	endfunction

	task automatic compare_word(input string what, input logic [31:0] got,
	                            input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic put_entry(input int i, input logic rw, input cache_pkg::addr_t a,
	                         input cache_pkg::word_t d);
		tab_rw[i]   = rw;
		tab_addr[i] = a;
		tab_data[i] = d;
	endtask

	task automatic build_table();
		logic [31:0] r;
		put_entry(0, 1'b0, 16'h0106, '0);           // tag 010 set 1, cold miss
		put_entry(1, 1'b0, 16'h0106, '0);           // same word hits
		put_entry(2, 1'b1, 16'h0107, 32'ha5a50001); // store hit, line dirty
		put_entry(3, 1'b0, 16'h0107, '0);           // reads the stored word back
		put_entry(4, 1'b0, 16'h0204, '0);           // tag 020 into way 1
		put_entry(5, 1'b0, 16'h0305, '0);           // tag 030 evicts dirty tag 010
		put_entry(6, 1'b0, 16'h0205, '0);           // tag 020 survives
		put_entry(7, 1'b0, 16'h0107, '0);           // 010 back, clean 020 evicted
		put_entry(8, 1'b1, 16'h0208, 32'h5a5a0002); // store miss in set 2
		put_entry(9, 1'b0, 16'h0208, '0);
		put_entry(10, 1'b0, 16'h0309, '0);
		put_entry(11, 1'b0, 16'h040a, '0);          // dirty 020 written back
		put_entry(12, 1'b0, 16'h0208, '0);          // stored word via next level
		for (int i = 13; i < TAB_LEN; i++) begin
			r = next_rand();
			put_entry(i, r[8], {10'h0, r[1:0], r[3:2], r[5:4]}, next_rand());  // 4 tags per set
		end
	endtask

	// one table entry, predicted from the reference cache
	task automatic run_access(input logic rw, input cache_pkg::addr_t a,
	                          input cache_pkg::word_t d);
		cache_pkg::tag_t  tg;
		logic [1:0]       st;
		logic             way, hit, evict_dirty;
		cache_pkg::addr_t old_base, new_base;
		tg  = a[15:4];
		st  = a[3:2];
		hit = 1'b0;
		way = 1'b0;
		if (ref_valid[st][0] && ref_tag[st][0] == tg) hit = 1'b1;
		if (ref_valid[st][1] && ref_tag[st][1] == tg) begin
			hit = 1'b1;
			way = 1'b1;
		end
		evict_dirty = 1'b0;
		old_base    = '0;
		if (!hit) begin
			way         = ref_ptr[st];  // oldest line goes
			evict_dirty = ref_valid[st][way] && ref_dirty[st][way];
			old_base    = {ref_tag[st][way], st, 2'b00};
		end
		new_base = {tg, st, 2'b00};
		cmd_q.delete();
		fill_words = 0;
		wb_words   = 0;
		wb_flags   = 0;

		@(negedge clock_i);
		core_req_i  = 1'b1;
		core_rw_i   = rw;
		core_addr_i = a;
		core_data_i = d;
		#1;
		compare_word("core_hit_o", 32'(core_hit_o), 32'(hit));  // same-cycle lookup
		@(negedge clock_i);
		core_req_i = 1'b0;
		if (hit) begin
			compare_word("flag_hit_o", 32'(flag_hit_o), 32'd1);
			compare_word("core_done_o on hit", 32'(core_done_o), 32'd1);
		end else begin
			compare_word("flag_miss_o", 32'(flag_miss_o), 32'd1);
			compare_word("core_done_o on miss", 32'(core_done_o), 32'd0);
			while (core_done_o !== 1'b1) @(negedge clock_i);  // watchdog guards this
		end

		// next-level traffic
		if (evict_dirty) begin
			compare_word("command count", 32'(cmd_q.size()), 32'd2);
			if (cmd_q.size() == 2) begin
				compare_word("write-back command", 32'(cmd_q[0]), 32'({1'b1, old_base}));
				compare_word("fill command", 32'(cmd_q[1]), 32'({1'b0, new_base}));
			end
			for (int k = 0; k < 4; k++) begin
				compare_word("written-back word", mem_model[old_base + 16'(k)],
				             arch_mem[old_base + 16'(k)]);
			end
		end else begin
			compare_word("command count", 32'(cmd_q.size()), hit ? 32'd0 : 32'd1);
			if (!hit && cmd_q.size() == 1) begin
				compare_word("fill command", 32'(cmd_q[0]), 32'({1'b0, new_base}));
			end
		end
		compare_word("fill words", 32'(fill_words), hit ? 32'd0 : 32'd4);
		compare_word("write-back words", 32'(wb_words), evict_dirty ? 32'd4 : 32'd0);
		compare_word("flag_writeback_o pulses", 32'(wb_flags), 32'(evict_dirty));

		if (rw) begin
			arch_mem[a] = d;
		end else begin
			compare_word("load data", core_data_o, arch_mem[a]);
		end
		if (!hit) begin
			ref_tag[st][way]   = tg;
			ref_valid[st][way] = 1'b1;
			ref_dirty[st][way] = 1'b0;
			ref_ptr[st]        = ~ref_ptr[st];
		end
		if (rw) ref_dirty[st][way] = 1'b1;
	endtask

	// next-level memory model
	// --------------------
	always @(negedge clock_i) begin
		logic [31:0] r;
		if (mem_req_o === 1'b1) begin
			cmd_q.push_back({mem_rw_o, mem_addr_o});
			if (mem_rw_o) begin
				wb_active = 1'b1;
				wb_base   = mem_addr_o;
				wb_idx    = 0;
			end else begin
				fill_active = 1'b1;
				fill_base   = mem_addr_o;
				fill_idx    = 0;
			end
		end
		if (flag_writeback_o === 1'b1) wb_flags++;
		r = next_rand();
		mem_ready_i  = r[1:0] != 2'b00;  // busy one cycle in four
		wb_ready_i   = r[3:2] != 2'b00;
		fill_valid_i = fill_active && (r[5:4] != 2'b00);
		fill_data_i  = mem_model[fill_base + 16'(fill_idx)];
		#1;
		// words move at the coming rising edge
		if (fill_ack_o === 1'b1) begin
			if (!fill_active) begin
				err_cnt++;
				$display("fill word acked with no fill command pending at %0t", $time);
			end
			fill_idx++;
			fill_words++;
			if (fill_idx == 4) fill_active = 1'b0;
		end
		if (wb_valid_o === 1'b1 && wb_ready_i) begin
			if (!wb_active) begin
				err_cnt++;
				$display("write-back word sent with no write command pending at %0t", $time);
			end
			mem_model[wb_base + 16'(wb_idx)] = wb_data_o;
			wb_idx++;
			wb_words++;
			if (wb_idx == 4) wb_active = 1'b0;
		end
	end

	initial begin
		#((20 + TAB_LEN * MISS_MAX) * 100);
		$display("watchdog expired, the cache stopped completing requests");
		$display("RESULT: FAIL");
		$finish;
	end

	// main sequence
	// --------------------
	initial begin
		resetn_i     = 1'b0;
		enable_i     = 1'b1;
		core_req_i   = 1'b0;
		core_rw_i    = 1'b0;
		core_addr_i  = '0;
		core_data_i  = '0;
		fill_valid_i = 1'b0;
		fill_data_i  = '0;
		wb_ready_i   = 1'b0;
		mem_ready_i  = 1'b0;
		fill_active  = 1'b0;
		wb_active    = 1'b0;
		fill_base    = '0;
		wb_base      = '0;
		err_cnt      = 0;
		check_cnt    = 0;
		for (int i = 0; i < 65536; i++) begin
			init_addr            = 16'(i);
			mem_model[init_addr] = xorshift(xorshift(32'h9b80 ^ {init_addr, ~init_addr}));
			arch_mem[init_addr]  = mem_model[init_addr];
		end
		ref_valid = '{default: '{default: 1'b0}};
		ref_dirty = '{default: '{default: 1'b0}};
		ref_ptr   = '{default: 1'b0};
		rng_q     = 32'h9b80;
		build_table();

		repeat (10) @(negedge clock_i);
		resetn_i = 1'b1;
		compare_word("core_done_o after reset", 32'(core_done_o), 32'd1);
		compare_word("mem_req_o after reset", 32'(mem_req_o), 32'd0);
		compare_word("wb_valid_o after reset", 32'(wb_valid_o), 32'd0);
		compare_word("fill_ack_o after reset", 32'(fill_ack_o), 32'd0);

		for (int i = 0; i < TAB_LEN; i++) begin
			run_access(tab_rw[i], tab_addr[i], tab_data[i]);
		end

		$display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: all.f
hw/cache_pkg.sv
hw/lookup_if.sv
hw/victim_if.sv
hw/tag_store.sv
hw/victim_select.sv
hw/cache_sequencer.sv
hw/l1_cache_top.sv
sim/tb_l1_cache.sv

// File: Makefile
TOP := tb_l1_cache

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/V$(TOP): all.f $(wildcard hw/*.sv) sim/tb_l1_cache.sv
	verilator --binary --timing --assert --top-module $(TOP) -f all.f

# status comes from the search for the pass line
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
